// File: common/sram_pkg.sv
// Sizes and address layout shared by the 128 KB main memory subsystem
// Address bits 1:0 are never decoded, so only whole words are stored
`default_nettype none

package sram_pkg;

    // Port widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MASK_W = 4;

    // 32K words across the whole memory
    localparam int WORD_AW = 15;

    // One macro is 16K x 16
    localparam int ROW_AW = 14;
    localparam int HALF_W = 16;
    localparam int NIB_W = 4;

    // Byte address seen two ways
    // flat is the raw port address, f splits it for decode
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            // Must be zero, else the access is outside the 128 KB window
            logic [ADDR_W-WORD_AW-3:0] upper;
            // Picks the macro pair
            logic [WORD_AW-ROW_AW-1:0] bank;
            // Row inside each macro
            logic [ROW_AW-1:0] row;
            // Byte within the word, not used
            logic [1:0] byte_off;
        } f;
    } mem_addr_u;

endpackage

`default_nettype wire

// File: sram/sp256k_macro.sv
// Behavioral 16K x 16 single-port SRAM, one-cycle registered read
// Standby, sleep and power-off pins are absent and assumed inactive
`timescale 1ns/1ps
`default_nettype none

module sp256k_macro
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic [ROW_AW-1:0] ad,
    input  logic [HALF_W-1:0] di,
    input  logic [NIB_W-1:0]  maskwe,
    input  logic              we,
    input  logic              cs,
    output logic [HALF_W-1:0] do_data
);

    // Storage, no reset, contents undefined at power-up
    logic [HALF_W-1:0] store [0:(1 << ROW_AW)-1];

    // Nibble writes, one enable per 4 data bits
    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int n = 0; n < NIB_W; n++) begin
                if (maskwe[n]) begin
                    store[ad][n*(HALF_W/NIB_W) +: HALF_W/NIB_W] <=
                        di[n*(HALF_W/NIB_W) +: HALF_W/NIB_W];
                end
            end
        end
    end

    // Output register
    // Old row contents come out during a write cycle
    // Holds its last value while deselected, like the hard macro
    always_ff @(posedge clk) begin
        if (cs) begin
            do_data <= store[ad];
        end
    end

endmodule

`default_nettype wire

// File: sram/sram_bank_array.sv
// 32K x 32 memory from four 16K x 16 macros in a 2 x 2 grid
// Read data follows en by one cycle; bits 1:0 of addr are ignored
`timescale 1ns/1ps
`default_nettype none

module sram_bank_array
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              en,
    input  logic              wr_en,
    input  logic [MASK_W-1:0] mask,
    output logic [DATA_W-1:0] rdata
);

    mem_addr_u         a;
    // One read word per bank, low half from macro 0, high half from macro 1
    logic [1:0][DATA_W-1:0] bank_rdata;
    // Bank of the last access
    logic              rmux;

    assign a.flat = addr;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        for (genvar h = 0; h < 2; h++) begin : g_half
            logic             cs;
            logic             we;
            logic [NIB_W-1:0] maskwe;

            // Only the addressed pair is selected
            assign cs = en && (a.f.bank == 1'(b));
            assign we = cs && wr_en;
            // Each byte enable covers two nibbles of this half
            assign maskwe = {{2{mask[h*2+1]}}, {2{mask[h*2]}}};

            sp256k_macro u_macro (
                .clk     (clk),
                .ad      (a.f.row),
                .di      (wdata[h*HALF_W +: HALF_W]),
                .maskwe  (maskwe),
                .we      (we),
                .cs      (cs),
                .do_data (bank_rdata[b][h*HALF_W +: HALF_W])
            );
        end
    end

    // Latch the bank only on an access
    // keeps rdata on the pair that was read, even after addr moves
    always_ff @(posedge clk) begin
        if (en) begin
            rmux <= a.f.bank;
        end
    end

    assign rdata = bank_rdata[rmux];

    // A write strobe without a chip enable would be lost silently
    a_wr_needs_en: assert property (@(posedge clk) wr_en |-> en)
        else $error("wr_en high without en");

endmodule

`default_nettype wire

// File: hw/mem_req_stage.sv
// Front end of the four-phase port, one transaction at a time
// Out-of-window requests get issue with issue_err and no memory cycle
`timescale 1ns/1ps
`default_nettype none

module mem_req_stage
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              wr_en,
    input  logic [MASK_W-1:0] mask,
    input  logic              release_pulse,
    output logic              mem_en,
    output logic              mem_wr_en,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    output logic [MASK_W-1:0] mem_mask,
    output logic              issue,
    output logic              issue_err
);

    // Two-state machine, idle when low
    logic      busy;
    mem_addr_u req_a;
    logic      in_window;
    logic      accept;

    assign req_a.flat = addr;
    // Anything above 128 KB is an error
    assign in_window = (req_a.f.upper == '0);

    // Release ends the old transaction in the same cycle
    // a req seen then is already a new one
    assign accept = req && (!busy || release_pulse);

    // Control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            issue     <= 1'b0;
            issue_err <= 1'b0;
            mem_en    <= 1'b0;
            mem_wr_en <= 1'b0;
        end else begin
            // All strobes are single-cycle pulses
            issue     <= accept;
            issue_err <= accept && !in_window;
            mem_en    <= accept && in_window;
            mem_wr_en <= accept && in_window && wr_en;

            if (accept) begin
                busy <= 1'b1;
            end else if (release_pulse) begin
                busy <= 1'b0;
            end
        end
    end

    // Request payload
    // requester holds these stable, but latch anyway for a clean memory cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_addr  <= addr;
            mem_wdata <= wdata;
            mem_mask  <= mask;
        end
    end

    // Release only ends a transaction already past its issue cycle
    // so no new issue can overlap one still in flight
    a_release_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        release_pulse |-> (busy && !issue)
    ) else $error("release while idle or in the issue cycle");

    // One memory cycle per transaction
    a_mem_en_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_en |=> !mem_en
    ) else $error("mem_en held two cycles");

endmodule

`default_nettype wire

// File: hw/mem_resp_stage.sv
// Back end of the four-phase port, ack two edges after the request is taken
// rdata and err stay put until the next transaction completes
`timescale 1ns/1ps
`default_nettype none

module mem_resp_stage
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req,
    input  logic              issue,
    input  logic              issue_err,
    input  logic [DATA_W-1:0] mem_rdata,
    output logic              ack,
    output logic [DATA_W-1:0] rdata,
    output logic              err,
    output logic              release_pulse
);

    // issue delayed to line up with the macro output register
    logic issue_d;
    logic issue_err_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_d       <= 1'b0;
            issue_err_d   <= 1'b0;
            ack           <= 1'b0;
            err           <= 1'b0;
            rdata         <= '0;
            release_pulse <= 1'b0;
        end else begin
            issue_d       <= issue;
            issue_err_d   <= issue_err;
            release_pulse <= 1'b0;

            if (issue_d) begin
                // Memory word is valid now
                // error returns zero
                ack   <= 1'b1;
                err   <= issue_err_d;
                rdata <= issue_err_d ? '0 : mem_rdata;
            end else if (ack && !req) begin
                // Phase 4, drop ack and free the request stage
                ack           <= 1'b0;
                release_pulse <= 1'b1;
            end
        end
    end

    // Requester must still be holding req when the answer arrives
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose while req low");

endmodule

`default_nettype wire

// File: hw/sram_subsys_top.sv
// 128 KB word memory behind a four-phase req/ack port
// Requester must see ack low before raising req again
`timescale 1ns/1ps
`default_nettype none

module sram_subsys_top
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              wr_en,
    input  logic [MASK_W-1:0] mask,
    output logic              ack,
    output logic [DATA_W-1:0] rdata,
    output logic              err
);

    // Request stage to memory
    logic              mem_en;
    logic              mem_wr_en;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [MASK_W-1:0] mem_mask;
    logic [DATA_W-1:0] mem_rdata;
    // Between the two handshake stages
    logic              issue;
    logic              issue_err;
    logic              release_pulse;

    mem_req_stage u_req (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .addr          (addr),
        .wdata         (wdata),
        .wr_en         (wr_en),
        .mask          (mask),
        .release_pulse (release_pulse),
        .mem_en        (mem_en),
        .mem_wr_en     (mem_wr_en),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_mask      (mem_mask),
        .issue         (issue),
        .issue_err     (issue_err)
    );

    sram_bank_array u_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .en    (mem_en),
        .wr_en (mem_wr_en),
        .mask  (mem_mask),
        .rdata (mem_rdata)
    );

    mem_resp_stage u_resp (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .issue         (issue),
        .issue_err     (issue_err),
        .mem_rdata     (mem_rdata),
        .ack           (ack),
        .rdata         (rdata),
        .err           (err),
        .release_pulse (release_pulse)
    );

endmodule

`default_nettype wire

// File: tb/tb_sram_subsys.sv
// Random four-phase master with a byte-level memory model, stops at the first mismatch
// Bytes never written are not compared since macro contents start undefined
`timescale 1ns/1ps
`default_nettype none

module tb_sram_subsys
    import sram_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int MAX_GAP       = 3;
    localparam int MAX_LONG_HOLD = 60;
    // Gap + 3 edges to ack + longest hold + ack fall, rounded up
    localparam int TXN_CYCLES    = 80;
    localparam int MAX_TXN       = 800;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + 4 + MAX_TXN * TXN_CYCLES) * CLK_PERIOD;

    // Transaction counts per test
    localparam int N_FILL   = 40;
    localparam int N_MASKED = 40;
    localparam int N_BANK   = 8;
    localparam int N_OOW    = 20;
    localparam int N_LONG   = 10;
    localparam int N_MIXED  = 400;

    logic              clk;
    logic              arst_n;
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              wr_en;
    logic [MASK_W-1:0] mask;
    logic              ack;
    logic [DATA_W-1:0] rdata;
    logic              err;

    integer seed = 32'hba88;
    // Expected byte per byte address, plus which bytes hold known data
    logic [7:0]        model_mem [int unsigned];
    bit                written [int unsigned];
    // In-window addresses already written
    logic [ADDR_W-1:0] pool [$];
    bit                long_holds;

    sram_subsys_top dut (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .addr   (addr),
        .wdata  (wdata),
        .wr_en  (wr_en),
        .mask   (mask),
        .ack    (ack),
        .rdata  (rdata),
        .err    (err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $fatal(1);
    end

    task automatic fail_check(input string what);
        $display("ERROR %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // Upper 15 bits zero, then bank, row, byte offset
    function automatic logic [31:0] window_addr(input logic bank, input logic [13:0] row,
                                                input logic [1:0] off);
        return {15'd0, bank, row, off};
    endfunction

    // At least one upper bit set
    function automatic logic [31:0] outside_addr();
        logic [31:0] a;
        a = rand_word();
        a[31:17] = a[31:17] | (15'd1 << rand_below(15));
        return a;
    endfunction

    // Word index from bits 16:2, lane picks the byte
    function automatic int unsigned byte_key(input logic [31:0] a, input logic [1:0] lane);
        return {15'd0, a[16:2], lane};
    endfunction

    function automatic int unsigned pick_hold();
        if (long_holds || rand_below(8) == 0) begin
            return 10 + rand_below(MAX_LONG_HOLD - 9);
        end
        return rand_below(4);
    endfunction

    // One full four-phase cycle, entered and left just after a rising edge
    task automatic run_txn(input logic [31:0] a, input logic we, input logic [31:0] wd,
                           input logic [3:0] m, output logic [31:0] rd, output logic er);
        int unsigned gap;
        int unsigned hold;
        gap = rand_below(MAX_GAP + 1);
        hold = pick_hold();
        repeat (gap) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        addr = a;
        wdata = wd;
        wr_en = we;
        mask = m;
        req = 1'b1;
        // Edge 1 takes the request, ack must show after edge 3
        for (int e = 1; e <= 3; e++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (e < 3) begin
                assert (ack == 1'b0)
                    else fail_check($sformatf("ack high early, %0d edges after req", e));
            end else begin
                assert (ack == 1'b1)
                    else fail_check("ack not high 2 edges after request was taken");
            end
        end
        rd = rdata;
        er = err;
        repeat (hold) begin
            @(posedge clk);
            #DRIVE_DLY;
            assert (ack == 1'b1 && rdata == rd && err == er)
                else fail_check("ack, rdata or err changed while req was held");
        end
        req = 1'b0;
        // Port fields are don't care once req is low
        addr = rand_word();
        wdata = rand_word();
        wr_en = 1'(rand_below(2));
        mask = 4'(rand_below(16));
        @(posedge clk);
        #DRIVE_DLY;
        assert (ack == 1'b0)
            else fail_check("ack still high after req was sampled low");
        assert (rdata == rd && err == er)
            else fail_check("rdata or err not held after ack fell");
    endtask

    task automatic write_word(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] m);
        logic [31:0] rd;
        logic        er;
        logic        exp_err;
        exp_err = (a[31:17] != 15'd0);
        run_txn(a, 1'b1, wd, m, rd, er);
        assert (er == exp_err)
            else fail_check($sformatf("write %h err %0b expected %0b", a, er, exp_err));
        if (exp_err) begin
            assert (rd == 32'd0)
                else fail_check($sformatf("write %h out of window rdata %h", a, rd));
        end else begin
            for (int i = 0; i < MASK_W; i++) begin
                if (m[i]) begin
                    model_mem[byte_key(a, 2'(i))] = wd[i*8 +: 8];
                    written[byte_key(a, 2'(i))] = 1'b1;
                end
            end
        end
    endtask

    task automatic read_check(input logic [31:0] a);
        logic [31:0] rd;
        logic        er;
        int unsigned key;
        run_txn(a, 1'b0, rand_word(), 4'(rand_below(16)), rd, er);
        if (a[31:17] != 15'd0) begin
            assert (er == 1'b1 && rd == 32'd0)
                else fail_check($sformatf("read %h out of window err %0b rdata %h", a, er, rd));
        end else begin
            assert (er == 1'b0)
                else fail_check($sformatf("read %h in window flagged err", a));
            for (int i = 0; i < MASK_W; i++) begin
                key = byte_key(a, 2'(i));
                if (written.exists(key)) begin
                    assert (rd[i*8 +: 8] == model_mem[key])
                        else fail_check($sformatf("read %h lane %0d got %h expected %h",
                                                  a, i, rd[i*8 +: 8], model_mem[key]));
                end
            end
        end
    endtask

    initial begin : main
        logic [31:0] a;
        logic [31:0] b;
        logic [13:0] row;
        int unsigned kind;
        req = 1'b0;
        addr = '0;
        wdata = '0;
        wr_en = 1'b0;
        mask = '0;
        arst_n = 1'b0;
        long_holds = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            assert (ack == 1'b0) else fail_check("ack high during reset");
        end
        arst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        assert (ack == 1'b0 && err == 1'b0 && rdata == 32'd0)
            else fail_check("outputs not idle after reset");

        // Full words over both banks, then read everything back
        for (int i = 0; i < N_FILL; i++) begin
            a = window_addr(1'(i % 2), 14'(rand_below(1 << ROW_AW)), 2'(rand_below(4)));
            write_word(a, rand_word(), 4'hf);
            pool.push_back(a);
        end
        foreach (pool[i]) begin
            read_check(pool[i]);
        end

        // Partial writes on top of known words
        for (int i = 0; i < N_MASKED; i++) begin
            a = pool[rand_below(pool.size())];
            write_word(a, rand_word(), 4'(rand_below(16)));
            read_check(a);
        end

        // Same row in both banks, and offset aliasing
        for (int i = 0; i < N_BANK; i++) begin
            row = 14'(rand_below(1 << ROW_AW));
            a = window_addr(1'b0, row, 2'd0);
            b = window_addr(1'b1, row, 2'd0);
            write_word(a, rand_word(), 4'hf);
            write_word(b, rand_word(), 4'hf);
            read_check(a);
            read_check(b);
            write_word(window_addr(1'b0, row, 2'(rand_below(4))), rand_word(), 4'hf);
            read_check(window_addr(1'b0, row, 2'(rand_below(4))));
            pool.push_back(a);
            pool.push_back(b);
        end

        // Out-of-window traffic must leave memory alone
        for (int i = 0; i < N_OOW; i++) begin
            write_word(outside_addr(), rand_word(), 4'(rand_below(16)));
            read_check(outside_addr());
        end
        foreach (pool[i]) begin
            read_check(pool[i]);
        end

        // Requester sits on req for a long time
        long_holds = 1'b1;
        for (int i = 0; i < N_LONG / 2; i++) begin
            a = pool[rand_below(pool.size())];
            write_word(a, rand_word(), 4'(rand_below(16)));
            read_check(a);
        end
        long_holds = 1'b0;

        // Mixed reads, writes and errors
        for (int i = 0; i < N_MIXED; i++) begin
            kind = rand_below(8);
            if (kind == 0) begin
                if (rand_below(2) == 0) begin
                    write_word(outside_addr(), rand_word(), 4'(rand_below(16)));
                end else begin
                    read_check(outside_addr());
                end
            end else if (kind <= 3) begin
                write_word(pool[rand_below(pool.size())], rand_word(), 4'(rand_below(16)));
            end else if (kind <= 5) begin
                a = window_addr(1'(rand_below(2)), 14'(rand_below(1 << ROW_AW)), 2'd0);
                write_word(a, rand_word(), 4'hf);
                pool.push_back(a);
            end else begin
                read_check(pool[rand_below(pool.size())]);
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/sram_pkg.sv
sram/sp256k_macro.sv
sram/sram_bank_array.sv
hw/mem_req_stage.sv
hw/mem_resp_stage.sv
hw/sram_subsys_top.sv
tb/tb_sram_subsys.sv

// File: run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sram_subsys -f verilog.f -o sim_tb

# Let the log decide the result, even when the simulator exits non-zero
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

if ! grep -q "all tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation PASSED"
